/* logic/pcie_sb_consts.svh */
`ifndef PCIE_SB_CONSTS_SVH
`define PCIE_SB_CONSTS_SVH

// ----------------------------------------------------------------------
// Field widths
// ----------------------------------------------------------------------

// Physical and virtual function numbers
`define PCIE_SB_PF_W               3
`define PCIE_SB_VF_W               11

// Configuration strobe fields from the hard IP
`define PCIE_SB_CFG_CTL_W          16
`define PCIE_SB_CFG_ADDR_W         5

// RX checker error code
`define PCIE_SB_ERR_CODE_W         32

// ----------------------------------------------------------------------
// Configuration space addresses
// ----------------------------------------------------------------------
`define PCIE_SB_ADDR_DEVCTL        0
`define PCIE_SB_ADDR_MSIX          12

// ----------------------------------------------------------------------
// Error stretch
// ----------------------------------------------------------------------

// Cycles a code stays up after the last nonzero input
`define PCIE_SB_ERR_STRETCH_CYCLES 4

`endif

/* logic/pcie_sb_pkg.sv */
`include "pcie_sb_consts.svh"

package pcie_sb_pkg;

   // ----------------------------------------------------------------------
   // Configuration path
   // ----------------------------------------------------------------------

   // Decoded config addresses, everything else is ignored
   typedef enum logic [`PCIE_SB_CFG_ADDR_W-1:0] {
      DEVCTL = `PCIE_SB_ADDR_DEVCTL,
      MSIX   = `PCIE_SB_ADDR_MSIX
   } cfg_addr_e;

   // One tl_cfg strobe payload
   typedef struct packed {
      logic [`PCIE_SB_PF_W-1:0]      func_num;
      cfg_addr_e                     addr;
      logic [`PCIE_SB_CFG_CTL_W-1:0] ctl;
   } tl_cfg_t;

   // Device control record for PF0
   typedef struct packed {
      logic [2:0] max_payload_size;
      logic [2:0] max_read_req_size;
      logic       extended_tag_enable;
      logic       msix_enable;
      logic       msix_pf_mask_en;
   } cfg_ctl_t;

   // ----------------------------------------------------------------------
   // FLR path
   // ----------------------------------------------------------------------

   // Function under reset
   typedef struct packed {
      logic                     vf_active;
      logic [`PCIE_SB_PF_W-1:0] pf_num;
      logic [`PCIE_SB_VF_W-1:0] vf_num;
   } flr_func_t;

   // FLR handler states
   typedef enum logic [1:0] {
      IDLE     = 2'd0,
      REQ      = 2'd1,
      WAIT_RSP = 2'd2,
      DONE     = 2'd3
   } flr_state_e;

endpackage

/* logic/cfg_ctl_decoder.sv */
`timescale 1ns/1ps

module cfg_ctl_decoder (
   input  logic                   avl_clk,
   input  logic                   reset_status_n,

   // Config strobes from the link side
   input  logic                   tl_cfg_valid_i,
   input  pcie_sb_pkg::tl_cfg_t   tl_cfg_i,

   // Decoded device control
   output pcie_sb_pkg::cfg_ctl_t  cfg_ctl_o,
   output logic                   link_up_o
);

   logic                  cfg_accept;
   logic                  devctl_hit;
   pcie_sb_pkg::cfg_ctl_t cfg_ctl_next;

   // Only PF0 strobes are of interest
   assign cfg_accept = tl_cfg_valid_i && (tl_cfg_i.func_num == '0);
   assign devctl_hit = cfg_accept && (tl_cfg_i.addr == pcie_sb_pkg::DEVCTL);

   // ----------------------------------------------------------------------
   // Field update
   // ----------------------------------------------------------------------
   always_comb begin
      cfg_ctl_next = cfg_ctl_o;
      if (cfg_accept) begin
         case (tl_cfg_i.addr)
            pcie_sb_pkg::DEVCTL: begin
               cfg_ctl_next.max_payload_size    = tl_cfg_i.ctl[2:0];
               cfg_ctl_next.max_read_req_size   = tl_cfg_i.ctl[5:3];
               cfg_ctl_next.extended_tag_enable = tl_cfg_i.ctl[6];
            end
            pcie_sb_pkg::MSIX: begin
               // MSI-X capability status bits
               cfg_ctl_next.msix_enable     = tl_cfg_i.ctl[5];
               cfg_ctl_next.msix_pf_mask_en = tl_cfg_i.ctl[6];
            end
            default: begin
               cfg_ctl_next = cfg_ctl_o;
            end
         endcase
      end
   end

   // ----------------------------------------------------------------------
   // Registers
   // ----------------------------------------------------------------------
   always_ff @(posedge avl_clk) begin
      if (!reset_status_n) begin
         cfg_ctl_o <= '0;
      end else begin
         cfg_ctl_o <= cfg_ctl_next;
      end
   end

   // Sticky until reset, first DEVCTL write marks the link usable
   always_ff @(posedge avl_clk) begin
      if (!reset_status_n) begin
         link_up_o <= 1'b0;
      end else if (devctl_hit) begin
         link_up_o <= 1'b1;
      end
   end

endmodule

/* logic/flr_fsm.sv */
`timescale 1ns/1ps

module flr_fsm (
   input  logic                   avl_clk,
   input  logic                   reset_status_n,

   // FLR received from the link
   input  logic                   flr_rcvd_valid_i,
   input  pcie_sb_pkg::flr_func_t flr_rcvd_i,

   // Application response
   input  logic                   flr_rsp_valid_i,

   // Request toward the application
   output logic                   flr_req_valid_o,
   output pcie_sb_pkg::flr_func_t flr_req_o,

   // Completion back toward the link
   output logic                   flr_completed_valid_o,
   output pcie_sb_pkg::flr_func_t flr_completed_o
);

   pcie_sb_pkg::flr_state_e state_q;
   pcie_sb_pkg::flr_state_e state_next;
   pcie_sb_pkg::flr_func_t  func_q;
   logic                    start_flr;

   // New FLR only taken when nothing is in flight
   assign start_flr = (state_q == pcie_sb_pkg::IDLE) && flr_rcvd_valid_i;

   // ----------------------------------------------------------------------
   // Next state
   // ----------------------------------------------------------------------
   always_comb begin
      state_next = state_q;
      case (state_q)
         pcie_sb_pkg::IDLE: begin
            if (flr_rcvd_valid_i) begin
               state_next = pcie_sb_pkg::REQ;
            end
         end
         // Single cycle request pulse
         pcie_sb_pkg::REQ: begin
            state_next = pcie_sb_pkg::WAIT_RSP;
         end
         pcie_sb_pkg::WAIT_RSP: begin
            if (flr_rsp_valid_i) begin
               state_next = pcie_sb_pkg::DONE;
            end
         end
         pcie_sb_pkg::DONE: begin
            state_next = pcie_sb_pkg::IDLE;
         end
         default: begin
            state_next = pcie_sb_pkg::IDLE;
         end
      endcase
   end

   always_ff @(posedge avl_clk) begin
      if (!reset_status_n) begin
         state_q <= pcie_sb_pkg::IDLE;
      end else begin
         state_q <= state_next;
      end
   end

   // ----------------------------------------------------------------------
   // Function identity
   // ----------------------------------------------------------------------

   // Captured on leaving IDLE, held through completion
   always_ff @(posedge avl_clk) begin
      if (!reset_status_n) begin
         func_q <= '0;
      end else if (start_flr) begin
         func_q <= flr_rcvd_i;
      end
   end

   // Strobes decoded from state
   assign flr_req_valid_o       = (state_q == pcie_sb_pkg::REQ);
   assign flr_completed_valid_o = (state_q == pcie_sb_pkg::DONE);
   assign flr_req_o             = func_q;
   assign flr_completed_o       = func_q;

endmodule

/* logic/err_stretch_timer.sv */
`timescale 1ns/1ps
`include "pcie_sb_consts.svh"

module err_stretch_timer (
   input  logic                           avl_clk,
   input  logic                           reset_status_n,
   input  logic [`PCIE_SB_ERR_CODE_W-1:0] err_code_i,
   output logic [`PCIE_SB_ERR_CODE_W-1:0] err_code_o
);

   localparam int CNT_W = $clog2(`PCIE_SB_ERR_STRETCH_CYCLES + 1);

   logic [`PCIE_SB_ERR_CODE_W-1:0] acc_q;
   logic [CNT_W-1:0]               cnt_q;
   logic                           err_seen;
   logic                           cnt_idle;

   assign err_seen = (err_code_i != '0);
   assign cnt_idle = (cnt_q == '0);

   // ----------------------------------------------------------------------
   // Accumulator and hold counter
   // ----------------------------------------------------------------------
   always_ff @(posedge avl_clk) begin
      if (!reset_status_n) begin
         acc_q <= '0;
         cnt_q <= '0;
      end else if (err_seen) begin
         // Any new code restarts the hold window
         cnt_q <= CNT_W'(`PCIE_SB_ERR_STRETCH_CYCLES);
         if (cnt_idle) begin
            acc_q <= err_code_i;
         end else begin
            acc_q <= acc_q | err_code_i;
         end
      end else if (!cnt_idle) begin
         cnt_q <= cnt_q - 1'b1;
         // Last cycle of the window
         if (cnt_q == CNT_W'(1)) begin
            acc_q <= '0;
         end
      end
   end

   assign err_code_o = acc_q;

endmodule

/* logic/pcie_sideband_top.sv */
`timescale 1ns/1ps
`include "pcie_sb_consts.svh"

module pcie_sideband_top (
   input  logic                           avl_clk,
   input  logic                           reset_status_n,

   // Configuration strobes
   input  logic                           tl_cfg_valid_i,
   input  pcie_sb_pkg::tl_cfg_t           tl_cfg_i,
   output pcie_sb_pkg::cfg_ctl_t          cfg_ctl_o,
   output logic                           link_up_o,

   // FLR exchange
   input  logic                           flr_rcvd_valid_i,
   input  pcie_sb_pkg::flr_func_t         flr_rcvd_i,
   input  logic                           flr_rsp_valid_i,
   output logic                           flr_req_valid_o,
   output pcie_sb_pkg::flr_func_t         flr_req_o,
   output logic                           flr_completed_valid_o,
   output pcie_sb_pkg::flr_func_t         flr_completed_o,

   // RX checker error code
   input  logic [`PCIE_SB_ERR_CODE_W-1:0] chk_rx_err_code_i,
   output logic [`PCIE_SB_ERR_CODE_W-1:0] rx_err_code_o
);

   // ----------------------------------------------------------------------
   // Device control decode
   // ----------------------------------------------------------------------
   cfg_ctl_decoder u_cfg_ctl_decoder (
      .avl_clk        (avl_clk),
      .reset_status_n (reset_status_n),
      .tl_cfg_valid_i (tl_cfg_valid_i),
      .tl_cfg_i       (tl_cfg_i),
      .cfg_ctl_o      (cfg_ctl_o),
      .link_up_o      (link_up_o)
   );

   // ----------------------------------------------------------------------
   // FLR handler
   // ----------------------------------------------------------------------
   flr_fsm u_flr_fsm (
      .avl_clk               (avl_clk),
      .reset_status_n        (reset_status_n),
      .flr_rcvd_valid_i      (flr_rcvd_valid_i),
      .flr_rcvd_i            (flr_rcvd_i),
      .flr_rsp_valid_i       (flr_rsp_valid_i),
      .flr_req_valid_o       (flr_req_valid_o),
      .flr_req_o             (flr_req_o),
      .flr_completed_valid_o (flr_completed_valid_o),
      .flr_completed_o       (flr_completed_o)
   );

   // ----------------------------------------------------------------------
   // Error code stretch
   // ----------------------------------------------------------------------

   // Keeps short checker pulses visible to a slow reader
   err_stretch_timer u_err_stretch_timer (
      .avl_clk        (avl_clk),
      .reset_status_n (reset_status_n),
      .err_code_i     (chk_rx_err_code_i),
      .err_code_o     (rx_err_code_o)
   );

endmodule

/* tb/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen #(
   parameter int CLK_PERIOD_NS = 8,
   parameter int RESET_CYCLES  = 2
) (
   output logic clk_o,
   output logic reset_n_o
);

   initial begin
      clk_o = 1'b0;
   end

   always #(CLK_PERIOD_NS / 2) clk_o = ~clk_o;

   // Held low across RESET_CYCLES rising edges, released on a falling edge
   initial begin
      reset_n_o = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk_o);
      @(negedge clk_o);
      reset_n_o = 1'b1;
   end

endmodule

/* tb/pcie_sideband_assertions.sv */
`timescale 1ns/1ps

module pcie_sideband_assertions (
   input logic                   avl_clk,
   input logic                   reset_status_n,
   input logic                   flr_rcvd_valid_i,
   input logic                   flr_req_valid_i,
   input pcie_sb_pkg::flr_func_t flr_req_i,
   input logic                   flr_completed_valid_i,
   input pcie_sb_pkg::flr_func_t flr_completed_i
);

   logic                   busy_q;
   pcie_sb_pkg::flr_func_t last_req_q;

   // FLR in flight from the accepted receive strobe until the completion pulse
   always_ff @(posedge avl_clk) begin
      if (!reset_status_n) begin
         busy_q <= 1'b0;
      end else if (flr_completed_valid_i) begin
         busy_q <= 1'b0;
      end else if (flr_rcvd_valid_i) begin
         busy_q <= 1'b1;
      end
   end

   always_ff @(posedge avl_clk) begin
      if (!reset_status_n) begin
         last_req_q <= '0;
      end else if (flr_req_valid_i) begin
         last_req_q <= flr_req_i;
      end
   end

   // ----------------------------------------------------------------------
   // FLR protocol
   // ----------------------------------------------------------------------
   rcvd_while_busy: assert property (@(posedge avl_clk) disable iff (!reset_status_n)
      flr_rcvd_valid_i |-> !busy_q)
      else $error("FLR receive strobe arrived while the handler was busy");

   req_single_cycle: assert property (@(posedge avl_clk) disable iff (!reset_status_n)
      flr_req_valid_i |=> !flr_req_valid_i)
      else $error("FLR request strobe lasted two cycles");

   cpl_single_cycle: assert property (@(posedge avl_clk) disable iff (!reset_status_n)
      flr_completed_valid_i |=> !flr_completed_valid_i)
      else $error("FLR completion strobe lasted two cycles");

   cpl_identity: assert property (@(posedge avl_clk) disable iff (!reset_status_n)
      flr_completed_valid_i |-> (flr_completed_i == last_req_q))
      else $error("FLR completion identity differs from the last request");

endmodule

bind pcie_sideband_top pcie_sideband_assertions u_sideband_assertions (
   .avl_clk               (avl_clk),
   .reset_status_n        (reset_status_n),
   .flr_rcvd_valid_i      (flr_rcvd_valid_i),
   .flr_req_valid_i       (flr_req_valid_o),
   .flr_req_i             (flr_req_o),
   .flr_completed_valid_i (flr_completed_valid_o),
   .flr_completed_i       (flr_completed_o)
);

/* tb/pcie_sideband_tb.sv */
`timescale 1ns/1ps
`include "pcie_sb_consts.svh"

module pcie_sideband_tb;

   localparam int CLK_PERIOD_NS = 8;
   localparam int ERR_W         = `PCIE_SB_ERR_CODE_W;

   // Cycle budgets per test, the watchdog allows twice their sum
   localparam int RESET_BUDGET  = 4;
   localparam int CFG_BUDGET    = 20;
   localparam int FLR_BUDGET    = 48;
   localparam int STRAY_BUDGET  = 4;
   localparam int ERR_BUDGET    = 20;
   localparam int TIMEOUT_NS    = 2 * CLK_PERIOD_NS *
      (RESET_BUDGET + CFG_BUDGET + FLR_BUDGET + STRAY_BUDGET + ERR_BUDGET);

   logic                   avl_clk;
   logic                   reset_status_n;
   logic                   tl_cfg_valid;
   pcie_sb_pkg::tl_cfg_t   tl_cfg;
   pcie_sb_pkg::cfg_ctl_t  cfg_ctl;
   logic                   link_up;
   logic                   flr_rcvd_valid;
   pcie_sb_pkg::flr_func_t flr_rcvd;
   logic                   flr_rsp_valid;
   logic                   flr_req_valid;
   pcie_sb_pkg::flr_func_t flr_req;
   logic                   flr_cpl_valid;
   pcie_sb_pkg::flr_func_t flr_cpl;
   logic [ERR_W-1:0]       chk_err_code;
   logic [ERR_W-1:0]       rx_err_code;

   int                     cfg_errs;
   int                     flr_errs;
   int                     err_errs;
   logic [31:0]            lcg_state;
   pcie_sb_pkg::cfg_ctl_t  exp_cfg;
   logic                   exp_link;

   tb_clk_gen #(.CLK_PERIOD_NS(CLK_PERIOD_NS), .RESET_CYCLES(2)) u_clk_gen (
      .clk_o     (avl_clk),
      .reset_n_o (reset_status_n)
   );

   pcie_sideband_top UUT (
      .avl_clk               (avl_clk),
      .reset_status_n        (reset_status_n),
      .tl_cfg_valid_i        (tl_cfg_valid),
      .tl_cfg_i              (tl_cfg),
      .cfg_ctl_o             (cfg_ctl),
      .link_up_o             (link_up),
      .flr_rcvd_valid_i      (flr_rcvd_valid),
      .flr_rcvd_i            (flr_rcvd),
      .flr_rsp_valid_i       (flr_rsp_valid),
      .flr_req_valid_o       (flr_req_valid),
      .flr_req_o             (flr_req),
      .flr_completed_valid_o (flr_cpl_valid),
      .flr_completed_o       (flr_cpl),
      .chk_rx_err_code_i     (chk_err_code),
      .rx_err_code_o         (rx_err_code)
   );

   // ----------------------------------------------------------------------
   // Random source and reference model
   // ----------------------------------------------------------------------
   function automatic logic [31:0] rand32();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   // Device control record after one strobe, per the decode rules
   function automatic pcie_sb_pkg::cfg_ctl_t expect_cfg(input pcie_sb_pkg::cfg_ctl_t cur,
                                                        input pcie_sb_pkg::tl_cfg_t s);
      pcie_sb_pkg::cfg_ctl_t r;
      r = cur;
      if (s.func_num == 3'd0) begin
         if (s.addr == `PCIE_SB_CFG_ADDR_W'(`PCIE_SB_ADDR_DEVCTL)) begin
            r.max_payload_size    = s.ctl[2:0];
            r.max_read_req_size   = s.ctl[5:3];
            r.extended_tag_enable = s.ctl[6];
         end else if (s.addr == `PCIE_SB_CFG_ADDR_W'(`PCIE_SB_ADDR_MSIX)) begin
            r.msix_enable     = s.ctl[5];
            r.msix_pf_mask_en = s.ctl[6];
         end
      end
      return r;
   endfunction

   // ----------------------------------------------------------------------
   // Compare tasks
   // ----------------------------------------------------------------------
   task automatic check_cfg(input pcie_sb_pkg::cfg_ctl_t got, input logic got_link,
                            input pcie_sb_pkg::cfg_ctl_t exp, input logic exp_link_v,
                            input string what);
      if (got !== exp || got_link !== exp_link_v) begin
         $display("MISMATCH @%0t: %s cfg_ctl got %h link %b exp %h link %b",
                  $time, what, got, got_link, exp, exp_link_v);
         cfg_errs++;
      end
   endtask

   task automatic check_flr(input logic got_v, input pcie_sb_pkg::flr_func_t got,
                            input logic exp_v, input pcie_sb_pkg::flr_func_t exp,
                            input string what);
      if (got_v !== exp_v) begin
         $display("MISMATCH @%0t: %s valid got %b exp %b", $time, what, got_v, exp_v);
         flr_errs++;
      end else if (exp_v && got !== exp) begin
         $display("MISMATCH @%0t: %s function got %h exp %h", $time, what, got, exp);
         flr_errs++;
      end
   endtask

   task automatic check_err(input logic [ERR_W-1:0] got, input logic [ERR_W-1:0] exp,
                            input string what);
      if (got !== exp) begin
         $display("MISMATCH @%0t: %s error code got %h exp %h", $time, what, got, exp);
         err_errs++;
      end
   endtask

   // ----------------------------------------------------------------------
   // Directed tests
   // ----------------------------------------------------------------------
   task automatic test_reset();
      @(negedge avl_clk);
      check_cfg(cfg_ctl, link_up, '0, 1'b0, "after reset");
      check_flr(flr_req_valid, flr_req, 1'b0, '0, "request after reset");
      check_flr(flr_cpl_valid, flr_cpl, 1'b0, '0, "completion after reset");
      // Function identity outputs clear at reset too
      check_flr(1'b1, flr_req, 1'b1, '0, "request function after reset");
      check_flr(1'b1, flr_cpl, 1'b1, '0, "completion function after reset");
      check_err(rx_err_code, '0, "after reset");
   endtask

   task automatic send_cfg(input logic [2:0] func, input logic [4:0] addr,
                           input logic [15:0] ctl, input string what);
      pcie_sb_pkg::tl_cfg_t s;
      s.func_num = func;
      s.addr     = pcie_sb_pkg::cfg_addr_e'(addr);
      s.ctl      = ctl;
      exp_cfg    = expect_cfg(exp_cfg, s);
      if (func == 3'd0 && addr == `PCIE_SB_CFG_ADDR_W'(`PCIE_SB_ADDR_DEVCTL)) begin
         exp_link = 1'b1;
      end
      @(negedge avl_clk);
      tl_cfg_valid = 1'b1;
      tl_cfg       = s;
      @(negedge avl_clk);
      tl_cfg_valid = 1'b0;
      tl_cfg       = ~s;
      check_cfg(cfg_ctl, link_up, exp_cfg, exp_link, what);
   endtask

   task automatic test_cfg_decode();
      logic [31:0] r;
      exp_cfg  = '0;
      exp_link = 1'b0;
      r = rand32();
      // MSI-X first, link stays down until DEVCTL
      send_cfg(3'd0, 5'd12, 16'h0020, "MSIX enable before DEVCTL");
      send_cfg(3'd3, 5'd0, ~r[15:0], "DEVCTL for function 3");
      send_cfg(3'd0, 5'd7, 16'hffff, "address 7");
      send_cfg(3'd0, 5'd0, r[15:0], "first DEVCTL");
      send_cfg(3'd0, 5'd12, 16'h0040, "MSIX mask only");
      send_cfg(3'd3, 5'd12, 16'h0060, "MSIX for function 3");
      send_cfg(3'd0, 5'd0, r[31:16], "second DEVCTL");
      repeat (2) begin
         @(negedge avl_clk);
         check_cfg(cfg_ctl, link_up, exp_cfg, exp_link, "idle after config");
      end
   endtask

   task automatic run_flr(input pcie_sb_pkg::flr_func_t f, input int delay);
      @(negedge avl_clk);
      flr_rcvd_valid = 1'b1;
      flr_rcvd       = f;
      @(negedge avl_clk);
      flr_rcvd_valid = 1'b0;
      flr_rcvd       = ~f;
      check_flr(flr_req_valid, flr_req, 1'b1, f, "request pulse");
      check_flr(flr_cpl_valid, flr_cpl, 1'b0, f, "completion during request");
      repeat (delay) begin
         @(negedge avl_clk);
         check_flr(flr_req_valid, flr_req, 1'b0, f, "request after its pulse");
         check_flr(flr_cpl_valid, flr_cpl, 1'b0, f, "completion before response");
      end
      flr_rsp_valid = 1'b1;
      @(negedge avl_clk);
      flr_rsp_valid = 1'b0;
      check_flr(flr_cpl_valid, flr_cpl, 1'b1, f, "completion pulse");
      check_flr(flr_req_valid, flr_req, 1'b0, f, "request during completion");
      @(negedge avl_clk);
      check_flr(flr_cpl_valid, flr_cpl, 1'b0, f, "completion after its pulse");
   endtask

   task automatic test_flr_exchange();
      logic [31:0]            r;
      pcie_sb_pkg::flr_func_t f;
      for (int i = 0; i < 4; i++) begin
         r           = rand32();
         f.vf_active = r[0];
         f.pf_num    = r[3:1];
         f.vf_num    = r[14:4];
         run_flr(f, 1 + int'(r[18:16] % 3'd6));
      end
   endtask

   task automatic test_stray_rsp();
      @(negedge avl_clk);
      flr_rsp_valid = 1'b1;
      @(negedge avl_clk);
      flr_rsp_valid = 1'b0;
      check_flr(flr_cpl_valid, flr_cpl, 1'b0, '0, "completion after stray response");
      check_flr(flr_req_valid, flr_req, 1'b0, '0, "request after stray response");
      @(negedge avl_clk);
      check_flr(flr_cpl_valid, flr_cpl, 1'b0, '0, "late completion after stray response");
   endtask

   // Check the current output, then drive the next input
   task automatic err_step(input logic [ERR_W-1:0] drive, input logic [ERR_W-1:0] exp,
                           input string what);
      @(negedge avl_clk);
      check_err(rx_err_code, exp, what);
      chk_err_code = drive;
   endtask

   task automatic test_err_stretch();
      logic [ERR_W-1:0] a;
      logic [ERR_W-1:0] b;
      a = rand32() | 32'h1;
      b = rand32() | 32'h8000_0000;
      // Lone code
      err_step(a, '0, "before lone code");
      repeat (4) err_step('0, a, "lone code held");
      err_step('0, '0, "lone code expired");
      // Two codes two cycles apart
      err_step(a, '0, "before first code");
      err_step('0, a, "first code");
      err_step(b, a, "first code held");
      repeat (4) err_step('0, a | b, "ORed codes held");
      err_step('0, '0, "ORed codes expired");
   endtask

   // ----------------------------------------------------------------------
   // Sequence, watchdog and report
   // ----------------------------------------------------------------------
   initial begin
      tl_cfg_valid   = 1'b0;
      tl_cfg         = '0;
      flr_rcvd_valid = 1'b0;
      flr_rcvd       = '0;
      flr_rsp_valid  = 1'b0;
      chk_err_code   = '0;
      cfg_errs       = 0;
      flr_errs       = 0;
      err_errs       = 0;
      lcg_state      = 32'h81db9241;
      exp_cfg        = '0;
      exp_link       = 1'b0;
      wait (reset_status_n === 1'b1);
      test_reset();
      test_cfg_decode();
      test_flr_exchange();
      test_stray_rsp();
      test_err_stretch();
      $display("Error counts: cfg %0d, flr %0d, err %0d", cfg_errs, flr_errs, err_errs);
      if (cfg_errs + flr_errs + err_errs == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

   initial begin
      #(TIMEOUT_NS);
      $display("Timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
      $display("Some tests failed");
      $finish;
   end

endmodule

/* src.f */
+incdir+logic
logic/pcie_sb_pkg.sv
logic/cfg_ctl_decoder.sv
logic/flr_fsm.sv
logic/err_stretch_timer.sv
logic/pcie_sideband_top.sv
tb/tb_clk_gen.sv
tb/pcie_sideband_assertions.sv
tb/pcie_sideband_tb.sv

/* Makefile */
# Verilator simulation of the PCIe sideband logic

VERILATOR ?= verilator
TOP       ?= pcie_sideband_tb
FLIST     ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= All tests passed
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

# Build, run, then decide pass or fail from the log
sim:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
